// File: verilog/rename_pkg.sv
package rename_pkg;

	// ============================================================
	// register file sizing
	// ============================================================

	// physical registers in the pool, register 0 included
	localparam int PREGS = 64;

	// bits in one physical register name
	localparam int PREG_W = 6;

	// allocation lanes and free lanes per clock
	localparam int LANES = 4;

	// ============================================================
	// reset walk
	// ============================================================

	// names released on each walk cycle
	localparam int WALK_STEP = 8;

	// walk cycles needed to cover the whole pool
	localparam int WALK_CYCLES = 8;

	// ============================================================
	// types
	// ============================================================

	// one physical register name
	typedef logic [PREG_W-1:0] pregno_t;

	// free count, 0 up to PREGS inclusive
	typedef logic [PREG_W:0] count_t;

	// allocation request from the rename lanes
	typedef struct packed {
		// one bit per lane wanting a destination name
		logic [LANES-1:0] req;
	} alloc_req_t;

	// names handed back by commit
	typedef struct packed {
		// lane carries a tag to release
		logic [LANES-1:0] valid;
		// tag per lane, meaningful only where valid is set
		pregno_t [LANES-1:0] tag;
	} free_req_t;

	// names handed out, also used for the picker result
	typedef struct packed {
		// lane holds a name
		logic [LANES-1:0] valid;
		// name per lane
		pregno_t [LANES-1:0] name;
	} grant_t;

endpackage

// File: verilog/init_walk.sv
module init_walk (
	input  logic                clk,
	input  logic                rst,
	output logic                walk_en,
	output rename_pkg::pregno_t walk_base,
	output logic                busy
);

	// ============================================================
	// walk state
	// ============================================================

	typedef enum logic {
		WALK,
		READY
	} walk_state_t;

	walk_state_t state;

	// base of the final block of names
	localparam rename_pkg::pregno_t LAST_BASE =
		rename_pkg::pregno_t'(rename_pkg::WALK_STEP * (rename_pkg::WALK_CYCLES - 1));

	// reset parks the walk at block 0
	// one block of names is released per clock until the top block is done
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WALK;
			walk_base <= '0;
		end else begin
			case (state)
				WALK: begin
					walk_base <= walk_base + rename_pkg::pregno_t'(rename_pkg::WALK_STEP);
					// top block goes out this cycle
					if (walk_base == LAST_BASE) begin
						state <= READY;
					end
				end
				default: begin
					// idle for good, only a new reset walks again
					state <= READY;
				end
			endcase
		end
	end

	// the map and the counter follow the walk directly
	assign walk_en = (state == WALK);

	// outside view, nothing may allocate while the pool is filling
	assign busy = (state == WALK);

endmodule

// File: verilog/free_map.sv
module free_map (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   walk_en,
	input  rename_pkg::pregno_t    walk_base,
	input  rename_pkg::grant_t     take,
	input  rename_pkg::free_req_t  free_req,
	output rename_pkg::grant_t     pick,
	output logic [2:0]             freed_n
);

	// one bit per physical register, set means free
	logic [rename_pkg::PREGS-1:0] free_bits;

	// bits to set and clear on the next edge
	logic [rename_pkg::PREGS-1:0] set_mask;
	logic [rename_pkg::PREGS-1:0] clear_mask;

	// picker working copy, lowest bit dropped per lane
	logic [rename_pkg::PREGS-1:0] search;

	// index of the lowest set bit, 0 when none is set
	function automatic rename_pkg::pregno_t lowest_set(
		input logic [rename_pkg::PREGS-1:0] bits
	);
		rename_pkg::pregno_t idx;
		idx = '0;
		// scan downward so the last hit is the lowest
		for (int b = rename_pkg::PREGS - 1; b >= 0; b--) begin
			if (bits[b]) begin
				idx = rename_pkg::pregno_t'(b);
			end
		end
		return idx;
	endfunction

	// ============================================================
	// release side, walk blocks or commit frees
	// ============================================================

	always_comb begin
		set_mask = '0;
		freed_n = '0;
		if (walk_en) begin
			// whole block of eight at once
			for (int j = 0; j < rename_pkg::WALK_STEP; j++) begin
				set_mask[walk_base + rename_pkg::pregno_t'(j)] = 1'b1;
			end
		end else begin
			for (int i = 0; i < rename_pkg::LANES; i++) begin
				// only a busy register really comes back
				// set_mask catches the same tag on two lanes
				if (free_req.valid[i] && free_req.tag[i] != '0
						&& !free_bits[free_req.tag[i]]
						&& !set_mask[free_req.tag[i]]) begin
					set_mask[free_req.tag[i]] = 1'b1;
					freed_n = freed_n + 3'd1;
				end
			end
		end
		// zero register stays out of the pool
		set_mask[0] = 1'b0;
	end

	// ============================================================
	// allocate side
	// ============================================================

	always_comb begin
		clear_mask = '0;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			if (take.valid[l]) begin
				clear_mask[take.name[l]] = 1'b1;
			end
		end
	end

	// taken names are always free now, so they never meet a set bit
	always_ff @(posedge clk) begin
		if (rst) begin
			free_bits <= '0;
		end else begin
			free_bits <= (free_bits | set_mask) & ~clear_mask;
		end
	end

	// chained search, four distinct lowest free names
	// x & (x - 1) strips the lowest set bit for the next lane
	always_comb begin
		search = free_bits;
		pick = '0;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			pick.valid[l] = |search;
			pick.name[l] = lowest_set(search);
			search = search & (search - 1'b1);
		end
	end

endmodule

// File: verilog/free_count.sv
module free_count (
	input  logic                clk,
	input  logic                rst,
	input  logic                walk_en,
	input  rename_pkg::pregno_t walk_base,
	input  logic [2:0]          take_n,
	input  logic [2:0]          freed_n,
	output rename_pkg::count_t  count
);

	// names the walk adds this cycle
	rename_pkg::count_t walk_add;

	// ============================================================
	// walk contribution
	// ============================================================

	always_comb begin
		walk_add = '0;
		if (walk_en) begin
			// block 0 holds the zero register, one short
			if (walk_base == '0) begin
				walk_add = rename_pkg::count_t'(rename_pkg::WALK_STEP - 1);
			end else begin
				walk_add = rename_pkg::count_t'(rename_pkg::WALK_STEP);
			end
		end
	end

	// grants never exceed the count, so no underflow here
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + walk_add + rename_pkg::count_t'(freed_n)
				- rename_pkg::count_t'(take_n);
		end
	end

endmodule

// File: verilog/name_supplier.sv
module name_supplier (
	input  logic                  clk,
	input  logic                  rst,
	input  rename_pkg::alloc_req_t alloc_req,
	input  rename_pkg::free_req_t  free_req,
	output rename_pkg::grant_t     grant,
	output logic                  stall,
	output logic                  busy,
	output rename_pkg::count_t     avail_count
);

	logic                walk_en;
	rename_pkg::pregno_t walk_base;
	rename_pkg::grant_t  pick;
	rename_pkg::grant_t  take;
	logic [2:0]          freed_n;
	logic [2:0]          req_n;
	logic [2:0]          take_n;
	// next pick slot while steering
	logic [2:0]          slot;

	// ============================================================
	// submodules
	// ============================================================

	init_walk i_walk (
		.clk(clk),
		.rst(rst),
		.walk_en(walk_en),
		.walk_base(walk_base),
		.busy(busy)
	);

	free_map i_map (
		.clk(clk),
		.rst(rst),
		.walk_en(walk_en),
		.walk_base(walk_base),
		.take(take),
		.free_req(free_req),
		.pick(pick),
		.freed_n(freed_n)
	);

	free_count i_count (
		.clk(clk),
		.rst(rst),
		.walk_en(walk_en),
		.walk_base(walk_base),
		.take_n(take_n),
		.freed_n(freed_n),
		.count(avail_count)
	);

	// ============================================================
	// stall and lane steering
	// ============================================================

	// lanes asking this cycle
	always_comb begin
		req_n = '0;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			req_n = req_n + {2'b00, alloc_req.req[l]};
		end
	end

	// all or nothing, and nothing at all while the walk runs
	assign stall = (busy && |alloc_req.req)
		|| (rename_pkg::count_t'(req_n) > avail_count);

	// lowest picks go to requested lanes in ascending lane order
	always_comb begin
		take = '0;
		slot = '0;
		if (!stall && !busy) begin
			for (int l = 0; l < rename_pkg::LANES; l++) begin
				if (alloc_req.req[l]) begin
					take.valid[l] = pick.valid[slot[1:0]];
					take.name[l] = pick.name[slot[1:0]];
					slot = slot + 3'd1;
				end
			end
		end
	end

	// slot ends at the number of lanes served
	assign take_n = slot;

	// one cycle grant latency, names carry no reset
	always_ff @(posedge clk) begin
		if (rst) begin
			grant.valid <= '0;
		end else begin
			grant.valid <= take.valid;
		end
		grant.name <= take.name;
	end

endmodule

// File: tb/name_supplier_sva.sv
module name_supplier_sva (
	input logic               clk,
	input logic               rst,
	input rename_pkg::grant_t grant,
	input logic               stall,
	input logic               busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// assertion failures seen so far
	int fail_count = 0;

	// some valid lane carries the zero register
	function automatic logic zero_named(input rename_pkg::grant_t g);
		logic hit;
		hit = 1'b0;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			if (g.valid[l] && g.name[l] == '0) hit = 1'b1;
		end
		return hit;
	endfunction

	// two valid lanes share a name
	function automatic logic names_repeat(input rename_pkg::grant_t g);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < rename_pkg::LANES; i++) begin
			for (int j = i + 1; j < rename_pkg::LANES; j++) begin
				if (g.valid[i] && g.valid[j] && g.name[i] == g.name[j]) hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// ============================================================
	// grant rules
	// ============================================================

	a_no_zero: assert property (@(posedge clk) disable iff (rst) !zero_named(grant))
		else begin
			fail_count++;
			$error("grant names register 0");
		end

	a_distinct: assert property (@(posedge clk) disable iff (rst) !names_repeat(grant))
		else begin
			fail_count++;
			$error("grant repeats a name within one cycle");
		end

	// a stalled request leaves no grant behind
	a_stall_blocks: assert property (@(posedge clk) disable iff (rst)
		(stall && !busy) |=> (grant.valid == '0))
		else begin
			fail_count++;
			$error("grant issued after a stalled cycle");
		end

endmodule

// File: tb/name_supplier_tb.sv
module name_supplier_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// cycles allowed for the reset walk before giving up
	localparam int WALK_TIMEOUT = 50;

	// one stimulus row applied reps times in a row
	typedef struct packed {
		logic [rename_pkg::LANES-1:0] alloc;
		logic [rename_pkg::LANES-1:0] fmask;
		rename_pkg::pregno_t [rename_pkg::LANES-1:0] tags;
		logic rnd;
		int reps;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	rename_pkg::alloc_req_t alloc_req;
	rename_pkg::free_req_t free_req;
	rename_pkg::grant_t grant;
	logic stall;
	logic busy;
	rename_pkg::count_t avail_count;

	// reference model state
	logic [rename_pkg::PREGS-1:0] ref_free;
	rename_pkg::count_t ref_count;
	rename_pkg::grant_t exp_grant;
	logic [15:0] lfsr;
	int checks;
	int error_count;
	int walk_cycles;
	row_t rows[$];

	name_supplier i_dut (
		.clk(clk),
		.rst(rst),
		.alloc_req(alloc_req),
		.free_req(free_req),
		.grant(grant),
		.stall(stall),
		.busy(busy),
		.avail_count(avail_count)
	);

	bind name_supplier name_supplier_sva i_sva (
		.clk(clk),
		.rst(rst),
		.grant(grant),
		.stall(stall),
		.busy(busy)
	);

	always #10 clk = ~clk;

	// ============================================================
	// helpers
	// ============================================================

	// galois form with taps for a maximal 16-bit sequence
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one lfsr step per tag bit
	function automatic rename_pkg::pregno_t random_tag();
		rename_pkg::pregno_t t;
		for (int b = 0; b < rename_pkg::PREG_W; b++) begin
			t[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return t;
	endfunction

	function automatic int lanes_set(input logic [rename_pkg::LANES-1:0] m);
		int n;
		n = 0;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			n = n + int'(m[l]);
		end
		return n;
	endfunction

	task automatic add_row(input logic [3:0] alloc, input logic [3:0] fmask,
			input int t0, input int t1, input int t2, input int t3,
			input logic rnd, input int reps);
		row_t r;
		r.alloc = alloc;
		r.fmask = fmask;
		r.tags[0] = rename_pkg::pregno_t'(t0);
		r.tags[1] = rename_pkg::pregno_t'(t1);
		r.tags[2] = rename_pkg::pregno_t'(t2);
		r.tags[3] = rename_pkg::pregno_t'(t3);
		r.rnd = rnd;
		r.reps = reps;
		rows.push_back(r);
	endtask

	// ============================================================
	// compare tasks
	// ============================================================

	// names on lanes without valid are don't care
	task automatic check_grant(input string sig, input rename_pkg::grant_t got,
			input rename_pkg::grant_t exp);
		rename_pkg::grant_t got_m;
		rename_pkg::grant_t exp_m;
		got_m = got;
		exp_m = exp;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			if (!got.valid[l]) got_m.name[l] = '0;
			if (!exp.valid[l]) exp_m.name[l] = '0;
		end
		checks++;
		if (got_m !== exp_m) begin
			error_count++;
			$display("[FAIL] %s got %h expected %h at %0t", sig, got_m, exp_m, $time);
		end
	endtask

	task automatic check_flag(input string sig, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %s got %h expected %h at %0t", sig, got, exp, $time);
		end
	endtask

	task automatic check_count(input string sig, input rename_pkg::count_t got,
			input rename_pkg::count_t exp);
		checks++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %s got %h expected %h at %0t", sig, got, exp, $time);
		end
	endtask

	// ============================================================
	// reference model and row driver
	// ============================================================

	// lowest free names go to requested lanes and frees land after the picks
	task automatic predict_cycle(input rename_pkg::alloc_req_t a,
			input rename_pkg::free_req_t f, output logic exp_stall);
		logic [rename_pkg::PREGS-1:0] freed;
		logic [rename_pkg::PREGS-1:0] taken;
		int need;
		int idx;
		int n_freed;
		need = lanes_set(a.req);
		exp_stall = need > int'(ref_count);
		exp_grant = '0;
		taken = '0;
		freed = '0;
		n_freed = 0;
		idx = 0;
		if (!exp_stall) begin
			for (int l = 0; l < rename_pkg::LANES; l++) begin
				if (a.req[l]) begin
					while (idx < rename_pkg::PREGS && !ref_free[idx]) idx++;
					exp_grant.valid[l] = 1'b1;
					exp_grant.name[l] = rename_pkg::pregno_t'(idx);
					taken[idx] = 1'b1;
					idx++;
				end
			end
		end else begin
			need = 0;
		end
		// only a busy nonzero register comes back and only once
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			if (f.valid[l] && f.tag[l] != '0 && !ref_free[f.tag[l]] && !freed[f.tag[l]]) begin
				freed[f.tag[l]] = 1'b1;
				n_freed++;
			end
		end
		ref_free = (ref_free | freed) & ~taken;
		ref_count = rename_pkg::count_t'(int'(ref_count) + n_freed - need);
	endtask

	task automatic apply_cycle(input row_t row);
		logic exp_stall;
		@(posedge clk);
		#2;
		// registered results of the previous row cycle
		check_grant("grant", grant, exp_grant);
		check_count("avail_count", avail_count, ref_count);
		alloc_req.req = row.alloc;
		free_req.valid = row.fmask;
		for (int l = 0; l < rename_pkg::LANES; l++) begin
			if (row.rnd) free_req.tag[l] = random_tag();
			else free_req.tag[l] = row.tags[l];
		end
		#1;
		predict_cycle(alloc_req, free_req, exp_stall);
		check_flag("stall", stall, exp_stall);
	endtask

	task automatic finish_run();
		int sva_fails;
		sva_fails = i_dut.i_sva.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, error_count,
			sva_fails);
		if (error_count == 0 && sva_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		alloc_req = '0;
		free_req = '0;
		checks = 0;
		error_count = 0;
		lfsr = 16'd20511;
		exp_grant = '0;
		repeat (4) @(posedge clk);
		#2;
		check_flag("busy", busy, 1'b1);
		check_count("avail_count", avail_count, '0);
		rst = 1'b0;
		// a request and a free during the walk are both held off
		alloc_req.req = 4'b0001;
		free_req.valid = 4'b0001;
		free_req.tag[0] = rename_pkg::pregno_t'(9);
		walk_cycles = 0;
		while (busy && walk_cycles < WALK_TIMEOUT) begin
			#1;
			check_flag("stall", stall, 1'b1);
			check_flag("grant_valid", |grant.valid, 1'b0);
			@(posedge clk);
			#2;
			walk_cycles++;
		end
		if (busy) begin
			$display("busy still high after %0d cycles, reset walk never ended", WALK_TIMEOUT);
			error_count++;
			finish_run();
		end else begin
			alloc_req = '0;
			free_req = '0;
			if (walk_cycles != rename_pkg::WALK_CYCLES) begin
				error_count++;
				$display("[FAIL] walk_cycles got %h expected %h", walk_cycles,
					rename_pkg::WALK_CYCLES);
			end
			check_count("avail_count", avail_count, rename_pkg::count_t'(63));
			ref_free = {{(rename_pkg::PREGS-1){1'b1}}, 1'b0};
			ref_count = rename_pkg::count_t'(63);
			// alloc, free mask, tags 0..3, random tags, repeats
			add_row(4'b0001, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			add_row(4'b1111, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			add_row(4'b1010, 4'b0000, 0, 0, 0, 0, 1'b0, 2);
			add_row(4'b0000, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			// drain until stall and then hold
			add_row(4'b1111, 4'b0000, 0, 0, 0, 0, 1'b0, 16);
			add_row(4'b0100, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			add_row(4'b0011, 4'b0000, 0, 0, 0, 0, 1'b0, 2);
			// duplicate tag and register 0
			add_row(4'b0000, 4'b1111, 3, 3, 0, 10, 1'b0, 1);
			// name freed this cycle is not granted yet
			add_row(4'b0001, 4'b0001, 2, 0, 0, 0, 1'b0, 1);
			add_row(4'b0111, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			// second free of 5 finds it already free
			add_row(4'b0000, 4'b0001, 5, 0, 0, 0, 1'b0, 2);
			add_row(4'b0001, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			add_row(4'b0000, 4'b1111, 0, 0, 0, 0, 1'b1, 6);
			add_row(4'b0011, 4'b1111, 0, 0, 0, 0, 1'b1, 6);
			add_row(4'b1111, 4'b0000, 0, 0, 0, 0, 1'b0, 4);
			add_row(4'b1001, 4'b0110, 0, 0, 0, 0, 1'b1, 4);
			add_row(4'b0000, 4'b0000, 0, 0, 0, 0, 1'b0, 1);
			foreach (rows[r]) begin
				for (int k = 0; k < rows[r].reps; k++) begin
					apply_cycle(rows[r]);
				end
			end
			// registered results of the last row
			@(posedge clk);
			#2;
			check_grant("grant", grant, exp_grant);
			check_count("avail_count", avail_count, ref_count);
			finish_run();
		end
	end

endmodule

// File: tb.f
verilog/rename_pkg.sv
verilog/init_walk.sv
verilog/free_map.sv
verilog/free_count.sv
verilog/name_supplier.sv
tb/name_supplier_sva.sv
tb/name_supplier_tb.sv

// File: Makefile
# Verilator build and run for the name supplier testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := name_supplier_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the verdict
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "pass message missing in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
